/* src/video_pkg.sv */
// ####################################################################
// Raster types shared by the beam counter, the sprite channels and
// the colour output stage. Import with a wildcard in the module header.
// ####################################################################

`default_nettype none

package video_pkg;

	// Beam and sprite coordinates
	localparam int COORD_W = 10;
	typedef logic [COORD_W-1:0] coord_t;

	// Palette colour index as sent to the display
	localparam int COLOR_W = 8;
	typedef logic [COLOR_W-1:0] color_t;

	// Upper half of the colour index, supplied per sprite
	localparam int PAL_HI_W = 4;
	typedef logic [PAL_HI_W-1:0] pal_hi_t;

	// Shown where no opaque sprite pixel lies
	localparam color_t BG_COLOR = 8'h00;

endpackage

`default_nettype wire

/* src/sprite_pkg.sv */
// ####################################################################
// Sprite engine definitions: channel count, register map, external
// memory types and the pixel fetch state machine encoding.
// ####################################################################

`default_nettype none

package sprite_pkg;

	// Channel count and sprite geometry
	localparam int N_SPRITES       = 8;
	localparam int LOG2_SPRITES    = 3;
	localparam int SPRITE_DIM      = 16;
	localparam int LOG2_SPRITE_DIM = 4;

	typedef logic [LOG2_SPRITES-1:0] sprite_idx_t;

	// Register bus, ADDRESS = {zero[2:0], sprite[2:0], reg[3:0]}
	localparam int REG_ADDR_W = 10;
	localparam int REG_SEL_W  = 4;
	localparam int REG_DATA_W = 16;

	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [REG_DATA_W-1:0] reg_data_t;

	// Register offsets within one sprite
	localparam logic [REG_SEL_W-1:0] REG_X    = 4'd0;
	localparam logic [REG_SEL_W-1:0] REG_Y    = 4'd1;
	localparam logic [REG_SEL_W-1:0] REG_BASE = 4'd2;
	localparam logic [REG_SEL_W-1:0] REG_CTRL = 4'd3;

	// Control word fields
	localparam int CTRL_EN_BIT  = 0;
	localparam int CTRL_PAL_LSB = 4;

	// External bitmap memory, one pixel per word, low nibble 0 is transparent
	typedef logic [15:0] mem_addr_t;
	typedef logic [15:0] mem_data_t;

	typedef enum logic [1:0] {
		IDLE,
		READ_TOP,
		READ_SECOND,
		EMIT
	} fetch_state_t;

endpackage

`default_nettype wire

/* src/sprite_cand_if.sv */
// ####################################################################
// Carries the two highest priority sprite hits from the sprite bank
// to the pixel fetch engine, tagged with their beam coordinates.
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

interface sprite_cand_if
	import video_pkg::*;
	import sprite_pkg::*;
();

	// Topmost hitting sprite
	logic      top_valid;
	mem_addr_t top_addr;
	pal_hi_t   top_pal;

	// Next one down, fetched when the top pixel is transparent
	logic      second_valid;
	mem_addr_t second_addr;
	pal_hi_t   second_pal;

	// Beam position these candidates were computed for
	coord_t    cand_x;
	coord_t    cand_y;

	modport bank (
		output top_valid, top_addr, top_pal,
		output second_valid, second_addr, second_pal,
		output cand_x, cand_y
	);

	modport fetch (
		input top_valid, top_addr, top_pal,
		input second_valid, second_addr, second_pal,
		input cand_x, cand_y
	);

endinterface

`default_nettype wire

/* src/beam_counter.sv */
// ####################################################################
// Tracks the raster position from the display's tick pulses.
// H_tick restarts the line, V_tick restarts the frame.
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module beam_counter
	import video_pkg::*;
(
	input  logic   CLK,
	input  logic   RSTb,
	input  logic   H_tick,
	input  logic   V_tick,
	output coord_t beam_x,
	output coord_t beam_y
);

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			beam_x <= '0;
			beam_y <= '0;
		end
		else
		begin
			// One pixel per clock along the line
			if (H_tick)
				beam_x <= '0;
			else
				beam_x <= beam_x + coord_t'(1);

			// Frame start wins over a coincident line start
			if (V_tick)
				beam_y <= '0;
			else if (H_tick)
				beam_y <= beam_y + coord_t'(1);
		end
	end

endmodule

`default_nettype wire

/* src/memory_sprite.sv */
// ####################################################################
// One sprite channel. Holds the position, bitmap base and control
// registers and registers the hit test and pixel word address for
// the current beam position.
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module memory_sprite
	import video_pkg::*;
	import sprite_pkg::*;
(
	input  logic                 CLK,
	input  logic                 RSTb,
	input  logic                 wr,
	input  logic [REG_SEL_W-1:0] reg_sel,
	input  reg_data_t            wr_data,
	input  coord_t               beam_x,
	input  coord_t               beam_y,
	output logic                 hit,
	output mem_addr_t            pix_addr,
	output pal_hi_t              pal_hi
);

	coord_t    spr_x;
	coord_t    spr_y;
	mem_addr_t spr_base;
	logic      spr_en;
	pal_hi_t   spr_pal;

	coord_t    dx;
	coord_t    dy;
	logic      in_x;
	logic      in_y;
	mem_addr_t pix_off;

	// Register file
	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			spr_x    <= '0;
			spr_y    <= '0;
			spr_base <= '0;
			spr_en   <= 1'b0;
			spr_pal  <= '0;
		end
		else if (wr)
		begin
			case (reg_sel)
				REG_X:    spr_x    <= coord_t'(wr_data);
				REG_Y:    spr_y    <= coord_t'(wr_data);
				REG_BASE: spr_base <= mem_addr_t'(wr_data);
				REG_CTRL:
				begin
					spr_en  <= wr_data[CTRL_EN_BIT];
					spr_pal <= wr_data[CTRL_PAL_LSB +: $bits(pal_hi_t)];
				end
				default: ;
			endcase
		end
	end

	// Offsets from the sprite origin; only trusted when beam >= origin
	assign dx = beam_x - spr_x;
	assign dy = beam_y - spr_y;

	assign in_x = (beam_x >= spr_x) && (dx < SPRITE_DIM);
	assign in_y = (beam_y >= spr_y) && (dy < SPRITE_DIM);

	// Row major 16x16 bitmap, one word per pixel
	assign pix_off = mem_addr_t'({dy[LOG2_SPRITE_DIM-1:0], dx[LOG2_SPRITE_DIM-1:0]});

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
			hit <= 1'b0;
		else
			hit <= spr_en && in_x && in_y;
	end

	always_ff @(posedge CLK)
	begin
		pix_addr <= spr_base + pix_off;
		pal_hi   <= spr_pal;
	end

endmodule

`default_nettype wire

/* src/sprite_bank.sv */
// ####################################################################
// Register write decode, the eight sprite channels and the top-two
// priority selector. Higher sprite numbers are drawn on top.
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module sprite_bank
	import video_pkg::*;
	import sprite_pkg::*;
(
	input  logic        CLK,
	input  logic        RSTb,
	input  reg_addr_t   ADDRESS,
	input  reg_data_t   DATA_IN,
	input  logic        WR,
	input  coord_t      beam_x,
	input  coord_t      beam_y,
	sprite_cand_if.bank cand
);

	logic                 wr_ok;
	sprite_idx_t          wr_idx;
	logic [N_SPRITES-1:0] wr_sp;
	logic [N_SPRITES-1:0] hit_vec;
	mem_addr_t            addr_vec [N_SPRITES];
	pal_hi_t              pal_vec  [N_SPRITES];

	logic                 top_found;
	logic                 sec_found;
	mem_addr_t            top_addr_n;
	mem_addr_t            sec_addr_n;
	pal_hi_t              top_pal_n;
	pal_hi_t              sec_pal_n;

	// Beam position aligned with the hit registers
	coord_t               beam_x_d;
	coord_t               beam_y_d;

	// Writes above the sprite register window are dropped
	assign wr_ok  = WR && (ADDRESS[REG_ADDR_W-1:REG_SEL_W+LOG2_SPRITES] == '0);
	assign wr_idx = ADDRESS[REG_SEL_W +: LOG2_SPRITES];

	for (genvar j = 0; j < N_SPRITES; j++)
	begin : g_sprite
		assign wr_sp[j] = wr_ok && (wr_idx == sprite_idx_t'(j));

		memory_sprite u_sprite (
			.CLK      (CLK),
			.RSTb     (RSTb),
			.wr       (wr_sp[j]),
			.reg_sel  (ADDRESS[REG_SEL_W-1:0]),
			.wr_data  (DATA_IN),
			.beam_x   (beam_x),
			.beam_y   (beam_y),
			.hit      (hit_vec[j]),
			.pix_addr (addr_vec[j]),
			.pal_hi   (pal_vec[j])
		);
	end

	// First two hits scanning down from the highest number
	always_comb
	begin
		top_found  = 1'b0;
		sec_found  = 1'b0;
		top_addr_n = '0;
		sec_addr_n = '0;
		top_pal_n  = '0;
		sec_pal_n  = '0;
		for (int k = N_SPRITES - 1; k >= 0; k--)
		begin
			if (hit_vec[k] && !top_found)
			begin
				top_found  = 1'b1;
				top_addr_n = addr_vec[k];
				top_pal_n  = pal_vec[k];
			end
			else if (hit_vec[k] && !sec_found)
			begin
				sec_found  = 1'b1;
				sec_addr_n = addr_vec[k];
				sec_pal_n  = pal_vec[k];
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			cand.top_valid    <= 1'b0;
			cand.second_valid <= 1'b0;
			beam_x_d          <= '0;
			beam_y_d          <= '0;
			cand.cand_x       <= '0;
			cand.cand_y       <= '0;
		end
		else
		begin
			cand.top_valid    <= top_found;
			cand.second_valid <= sec_found;
			beam_x_d          <= beam_x;
			beam_y_d          <= beam_y;
			cand.cand_x       <= beam_x_d;
			cand.cand_y       <= beam_y_d;
		end
	end

	always_ff @(posedge CLK)
	begin
		cand.top_addr    <= top_addr_n;
		cand.top_pal     <= top_pal_n;
		cand.second_addr <= sec_addr_n;
		cand.second_pal  <= sec_pal_n;
	end

endmodule

`default_nettype wire

/* src/pixel_fetch.sv */
// ####################################################################
// Reads the winning sprite pixel from external memory over the
// rvalid/rready pair and emits the palette colour with its beam
// coordinates. Falls through to the second sprite on a transparent
// pixel. Candidates arriving while busy are skipped.
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module pixel_fetch
	import video_pkg::*;
	import sprite_pkg::*;
(
	input  logic         CLK,
	input  logic         RSTb,
	sprite_cand_if.fetch cand,
	output mem_addr_t    memory_address,
	output logic         rvalid,
	input  mem_data_t    memory_data,
	input  logic         rready,
	output color_t       color_index,
	output logic         color_valid,
	output coord_t       color_x,
	output coord_t       color_y
);

	fetch_state_t state;

	// Second candidate and palettes held for the duration of a fetch
	logic         sec_valid;
	mem_addr_t    sec_addr;
	pal_hi_t      top_pal;
	pal_hi_t      sec_pal;

	logic [3:0]   pix_nib;
	logic         pix_opaque;

	assign pix_nib    = memory_data[3:0];
	assign pix_opaque = (pix_nib != 4'h0);

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			state       <= IDLE;
			rvalid      <= 1'b0;
			color_valid <= 1'b0;
		end
		else
		begin
			color_valid <= 1'b0;
			case (state)
				IDLE:
				begin
					color_x <= cand.cand_x;
					color_y <= cand.cand_y;
					if (cand.top_valid)
					begin
						memory_address <= cand.top_addr;
						rvalid         <= 1'b1;
						sec_valid      <= cand.second_valid;
						sec_addr       <= cand.second_addr;
						top_pal        <= cand.top_pal;
						sec_pal        <= cand.second_pal;
						state          <= READ_TOP;
					end
					else
					begin
						// Nothing under the beam
						color_index <= BG_COLOR;
						color_valid <= 1'b1;
					end
				end

				READ_TOP:
				begin
					if (rready)
					begin
						rvalid <= 1'b0;
						if (pix_opaque)
						begin
							color_index <= color_t'({top_pal, pix_nib});
							color_valid <= 1'b1;
							state       <= EMIT;
						end
						else if (sec_valid)
						begin
							memory_address <= sec_addr;
							state          <= READ_SECOND;
						end
						else
						begin
							color_index <= BG_COLOR;
							color_valid <= 1'b1;
							state       <= EMIT;
						end
					end
				end

				READ_SECOND:
				begin
					// rvalid rises again one cycle after the first read closed
					if (!rvalid)
						rvalid <= 1'b1;
					else if (rready)
					begin
						rvalid      <= 1'b0;
						color_index <= pix_opaque ? color_t'({sec_pal, pix_nib}) : BG_COLOR;
						color_valid <= 1'b1;
						state       <= EMIT;
					end
				end

				EMIT:
					state <= IDLE;

				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/sprite_controller.sv */
// ####################################################################
// Sprite engine top level. Connects the beam counter, the sprite bank
// and the pixel fetch engine. Register writes come in on ADDRESS,
// DATA_IN and WR; bitmap pixels are read over rvalid/rready.
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module sprite_controller
	import video_pkg::*;
	import sprite_pkg::*;
(
	input  logic      CLK,
	input  logic      RSTb,
	input  reg_addr_t ADDRESS,
	input  reg_data_t DATA_IN,
	input  logic      WR,
	input  logic      V_tick,
	input  logic      H_tick,
	input  mem_data_t memory_data,
	input  logic      rready,
	output color_t    color_index,
	output logic      color_valid,
	output coord_t    color_x,
	output coord_t    color_y,
	output mem_addr_t memory_address,
	output logic      rvalid
);

	coord_t beam_x;
	coord_t beam_y;

	sprite_cand_if cand_bus ();

	beam_counter u_beam (
		.CLK    (CLK),
		.RSTb   (RSTb),
		.H_tick (H_tick),
		.V_tick (V_tick),
		.beam_x (beam_x),
		.beam_y (beam_y)
	);

	sprite_bank u_bank (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.ADDRESS (ADDRESS),
		.DATA_IN (DATA_IN),
		.WR      (WR),
		.beam_x  (beam_x),
		.beam_y  (beam_y),
		.cand    (cand_bus.bank)
	);

	pixel_fetch u_fetch (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.cand           (cand_bus.fetch),
		.memory_address (memory_address),
		.rvalid         (rvalid),
		.memory_data    (memory_data),
		.rready         (rready),
		.color_index    (color_index),
		.color_valid    (color_valid),
		.color_x        (color_x),
		.color_y        (color_y)
	);

endmodule

`default_nettype wire

/* test/sprite_controller_chk.sv */
// ####################################################################
// Concurrent checks on the sprite engine's memory handshake, its
// reset state and its colour strobe. Bound to sprite_controller.
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module sprite_controller_chk
	import sprite_pkg::*;
(
	input logic      CLK,
	input logic      RSTb,
	input logic      rvalid,
	input logic      rready,
	input mem_addr_t memory_address,
	input logic      color_valid
);

	// Request held steady until the memory accepts it
	a_req_hold: assert property (@(posedge CLK) disable iff (!RSTb)
		(rvalid && !rready) |=> (rvalid && $stable(memory_address)))
		else $error("memory request dropped or changed before rready");

	// Outputs quiet while reset is held
	a_reset_quiet: assert property (@(posedge CLK)
		!RSTb |=> (!rvalid && !color_valid))
		else $error("rvalid or color_valid high during reset");

	// Colour after a completed read is a single cycle pulse
	a_emit_once: assert property (@(posedge CLK) disable iff (!RSTb)
		($past(rvalid && rready) && color_valid) |=> !color_valid)
		else $error("color_valid longer than one cycle after a read");

	// No colour while a read is outstanding
	a_no_emit_busy: assert property (@(posedge CLK) disable iff (!RSTb)
		color_valid |-> !rvalid)
		else $error("color_valid raised while a read is pending");

endmodule

`default_nettype wire

/* test/tb_sprite_controller.sv */
// ####################################################################
// Testbench for the sprite engine. Programs sprites from a scenario
// table, answers bitmap reads from a memory model with random delays
// and checks every colour and read address against a reference model.
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module tb_sprite_controller
	import video_pkg::*;
	import sprite_pkg::*;
();

	localparam int FRAME_W     = 40;
	localparam int FRAME_H     = 30;
	localparam int N_ROWS      = 9;
	localparam int SETTLE      = 24;
	localparam int STALL_LIMIT = 64;
	localparam int HIST_LEN    = 4;
	localparam int PIPE_LAG    = 3;

	logic      CLK         = 1'b0;
	logic      RSTb        = 1'b0;
	reg_addr_t ADDRESS     = '0;
	reg_data_t DATA_IN     = '0;
	logic      WR          = 1'b0;
	logic      V_tick      = 1'b0;
	logic      H_tick      = 1'b0;
	mem_data_t memory_data = '0;
	logic      rready      = 1'b0;
	color_t    color_index;
	logic      color_valid;
	coord_t    color_x;
	coord_t    color_y;
	mem_addr_t memory_address;
	logic      rvalid;

	// Reference copy of the sprite registers
	coord_t    m_x    [N_SPRITES];
	coord_t    m_y    [N_SPRITES];
	mem_addr_t m_base [N_SPRITES];
	logic      m_en   [N_SPRITES];
	pal_hi_t   m_pal  [N_SPRITES];

	// Beam position per clock, for tagging each candidate
	coord_t    model_bx          = '0;
	coord_t    model_by          = '0;
	int        hist_ptr          = 0;
	coord_t    hist_x [HIST_LEN] = '{default: '0};
	coord_t    hist_y [HIST_LEN] = '{default: '0};
	coord_t    req_x             = '0;
	coord_t    req_y             = '0;
	coord_t    pix_x             = '0;
	coord_t    pix_y             = '0;

	// Scenario table
	string     row_name [N_ROWS];
	int        row_cnt  [N_ROWS];
	reg_addr_t row_addr [N_ROWS][4];
	reg_data_t row_data [N_ROWS][4];

	string     cur_name       = "reset";
	logic      check_en       = 1'b0;
	int        seed           = 32'h1309;
	int        h_cnt          = 0;
	int        v_cnt          = 0;
	int        since_color    = 0;
	int        read_no        = 0;
	int        delay_left     = 0;
	logic      delay_armed    = 1'b0;
	int        colors_checked = 0;
	int        opaque_seen    = 0;

	sprite_controller u_sprite_controller (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.ADDRESS        (ADDRESS),
		.DATA_IN        (DATA_IN),
		.WR             (WR),
		.V_tick         (V_tick),
		.H_tick         (H_tick),
		.memory_data    (memory_data),
		.rready         (rready),
		.color_index    (color_index),
		.color_valid    (color_valid),
		.color_x        (color_x),
		.color_y        (color_y),
		.memory_address (memory_address),
		.rvalid         (rvalid)
	);

	bind sprite_controller sprite_controller_chk u_chk (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.rvalid         (rvalid),
		.rready         (rready),
		.memory_address (memory_address),
		.color_valid    (color_valid)
	);

	always #2 CLK = ~CLK;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual)
			stop_run($sformatf("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
	endtask

	function automatic reg_addr_t reg_address(input int s, input int r);
		reg_address = reg_addr_t'(s * 16 + r);
	endfunction

	// Memory contents from the two low address nibbles
	function automatic mem_data_t bitmap_word(input mem_addr_t a);
		bitmap_word = {12'h000, a[7:4] ^ a[3:0]};
	endfunction

	// History slot with the beam position the fetch engine takes now
	function automatic int cand_slot();
		cand_slot = (hist_ptr + HIST_LEN - PIPE_LAG) % HIST_LEN;
	endfunction

	function automatic logic sprite_covers(input int s, input coord_t x, input coord_t y);
		int dx;
		int dy;
		dx = int'(x) - int'(m_x[s]);
		dy = int'(y) - int'(m_y[s]);
		sprite_covers = m_en[s] && dx >= 0 && dx < SPRITE_DIM && dy >= 0 && dy < SPRITE_DIM;
	endfunction

	function automatic mem_addr_t sprite_word_addr(input int s, input coord_t x, input coord_t y);
		int dx;
		int dy;
		dx = int'(x) - int'(m_x[s]);
		dy = int'(y) - int'(m_y[s]);
		sprite_word_addr = m_base[s] + mem_addr_t'(dy * SPRITE_DIM + dx);
	endfunction

	// Sprite of rank n among the hits counting down from the top
	// Returns -1 when there is none
	function automatic int nth_hit(input coord_t x, input coord_t y, input int n);
		int s;
		int found;
		nth_hit = -1;
		found = 0;
		for (s = N_SPRITES - 1; s >= 0; s--)
		begin
			if (sprite_covers(s, x, y))
			begin
				if (found == n && nth_hit < 0)
					nth_hit = s;
				found++;
			end
		end
	endfunction

	// Only the top two hits are looked at
	// The first opaque one wins
	function automatic color_t expected_color(input coord_t x, input coord_t y);
		int        n;
		int        s;
		logic      done;
		mem_data_t w;
		expected_color = BG_COLOR;
		done = 1'b0;
		for (n = 0; n < 2; n++)
		begin
			s = nth_hit(x, y, n);
			if (!done && s >= 0)
			begin
				w = bitmap_word(sprite_word_addr(s, x, y));
				if (w[3:0] != 4'h0)
				begin
					expected_color = {m_pal[s], w[3:0]};
					done = 1'b1;
				end
			end
		end
	endfunction

	task automatic model_write(input reg_addr_t a, input reg_data_t d);
		int s;
		s = int'(a[6:4]);
		if (a[9:7] == 3'b000)
		begin
			case (a[3:0])
				REG_X:    m_x[s] = coord_t'(d);
				REG_Y:    m_y[s] = coord_t'(d);
				REG_BASE: m_base[s] = d;
				REG_CTRL:
				begin
					m_en[s]  = d[CTRL_EN_BIT];
					m_pal[s] = d[CTRL_PAL_LSB +: 4];
				end
				default: ;
			endcase
		end
	endtask

	task automatic define_row(input int r, input string name);
		row_name[r] = name;
		row_cnt[r]  = 0;
	endtask

	task automatic add_write(input int r, input reg_addr_t a, input reg_data_t d);
		row_addr[r][row_cnt[r]] = a;
		row_data[r][row_cnt[r]] = d;
		row_cnt[r]++;
	endtask

	task automatic build_table();
		define_row(0, "reset_idle");
		define_row(1, "single_sprite");
		add_write(1, reg_address(2, 0), 16'd8);
		add_write(1, reg_address(2, 1), 16'd4);
		add_write(1, reg_address(2, 2), 16'h0100);
		add_write(1, reg_address(2, 3), 16'h0051);
		define_row(2, "two_overlap");
		add_write(2, reg_address(5, 0), 16'd14);
		add_write(2, reg_address(5, 1), 16'd8);
		add_write(2, reg_address(5, 2), 16'h0230);
		add_write(2, reg_address(5, 3), 16'h00A1);
		define_row(3, "three_overlap");
		add_write(3, reg_address(6, 0), 16'd12);
		add_write(3, reg_address(6, 1), 16'd6);
		add_write(3, reg_address(6, 2), 16'h0033);
		add_write(3, reg_address(6, 3), 16'h00C1);
		// Sprites 5 and 6 stacked on the same bitmap and transparent together
		define_row(4, "top_two_transparent");
		add_write(4, reg_address(6, 0), 16'd14);
		add_write(4, reg_address(6, 1), 16'd8);
		add_write(4, reg_address(6, 2), 16'h0230);
		define_row(5, "ignored_writes");
		add_write(5, 10'h283, 16'h00F1);
		add_write(5, reg_address(1, 7), 16'hFFFF);
		add_write(5, 10'h380, 16'h0000);
		add_write(5, reg_address(0, 9), 16'h00F1);
		define_row(6, "disable_top");
		add_write(6, reg_address(6, 3), 16'h00C0);
		define_row(7, "move_sprite");
		add_write(7, reg_address(2, 0), 16'd20);
		add_write(7, reg_address(2, 1), 16'd12);
		define_row(8, "wrap_base");
		add_write(8, reg_address(7, 0), 16'd30);
		add_write(8, reg_address(7, 1), 16'd20);
		add_write(8, reg_address(7, 2), 16'hFFF8);
		add_write(8, reg_address(7, 3), 16'h0031);
	endtask

	// Waits n clocks and stops if the colour output goes silent
	task automatic run_cycles(input int n);
		int i;
		for (i = 0; i < n; i++)
		begin
			@(negedge CLK);
			if (since_color > STALL_LIMIT)
				stop_run($sformatf("Timeout: no color_valid for %0d cycles", STALL_LIMIT));
		end
	endtask

	task automatic apply_row(input int r);
		int i;
		int start_checked;
		check_en = 1'b0;
		cur_name = row_name[r];
		for (i = 0; i < row_cnt[r]; i++)
		begin
			@(negedge CLK);
			ADDRESS = row_addr[r][i];
			DATA_IN = row_data[r][i];
			WR      = 1'b1;
			model_write(row_addr[r][i], row_data[r][i]);
		end
		@(negedge CLK);
		WR = 1'b0;
		// Let fetches started before the writes drain
		run_cycles(SETTLE);
		check_en = 1'b1;
		start_checked = colors_checked;
		run_cycles(2 * FRAME_W * FRAME_H);
		if (colors_checked == start_checked)
			stop_run($sformatf("No colour was checked in test %s", cur_name));
	endtask

	task automatic check_read();
		int s;
		if (read_no > 1)
			stop_run($sformatf("More than two memory reads for one pixel in %s", cur_name));
		else
		begin
			s = nth_hit(req_x, req_y, read_no);
			if (s < 0)
				stop_run($sformatf("Unexpected memory read at (%0d,%0d) in %s",
					req_x, req_y, cur_name));
			else
				check_value($sformatf("%s read %0d address at (%0d,%0d)", cur_name, read_no,
					req_x, req_y), int'(sprite_word_addr(s, req_x, req_y)),
					int'(memory_address));
		end
	endtask

	// Beam position from the tick rules, one history entry per clock
	always @(posedge CLK)
	begin
		if (!RSTb)
		begin
			model_bx = '0;
			model_by = '0;
		end
		else
		begin
			if (H_tick)
				model_bx = '0;
			else
				model_bx = model_bx + coord_t'(1);
			if (V_tick)
				model_by = '0;
			else if (H_tick)
				model_by = model_by + coord_t'(1);
		end
		hist_ptr = (hist_ptr + 1) % HIST_LEN;
		hist_x[hist_ptr] = model_bx;
		hist_y[hist_ptr] = model_by;
	end

	// Raster ticks, colour monitor and memory model
	always @(negedge CLK)
	begin
		H_tick = (h_cnt == FRAME_W - 1);
		V_tick = H_tick && (v_cnt == FRAME_H - 1);
		if (H_tick)
		begin
			h_cnt = 0;
			v_cnt = V_tick ? 0 : v_cnt + 1;
		end
		else
			h_cnt = h_cnt + 1;

		if (!RSTb)
			since_color = 0;
		else if (color_valid === 1'b1)
		begin
			since_color = 0;
			// Without a read the colour follows its candidate by one clock
			if (read_no == 0)
			begin
				pix_x = hist_x[cand_slot()];
				pix_y = hist_y[cand_slot()];
			end
			else
			begin
				pix_x = req_x;
				pix_y = req_y;
			end
			read_no = 0;
			if (check_en)
			begin
				check_value($sformatf("%s colour x", cur_name), int'(pix_x), int'(color_x));
				check_value($sformatf("%s colour y", cur_name), int'(pix_y), int'(color_y));
				check_value($sformatf("%s colour at (%0d,%0d)", cur_name, pix_x, pix_y),
					int'(expected_color(pix_x, pix_y)), int'(color_index));
				colors_checked++;
				if (color_index != BG_COLOR)
					opaque_seen++;
			end
		end
		else
			since_color++;

		// Accept each read after 0 to 3 cycles
		rready = 1'b0;
		if (rvalid === 1'b1)
		begin
			if (!delay_armed)
			begin
				delay_left  = $random(seed) & 3;
				delay_armed = 1'b1;
				// Top read opens one clock after the candidate was taken
				if (read_no == 0)
				begin
					req_x = hist_x[cand_slot()];
					req_y = hist_y[cand_slot()];
				end
			end
			if (delay_left == 0)
			begin
				if (check_en)
					check_read();
				memory_data = bitmap_word(memory_address);
				rready      = 1'b1;
				delay_armed = 1'b0;
				read_no++;
			end
			else
				delay_left--;
		end
	end

	initial
	begin
		int r;
		for (r = 0; r < N_SPRITES; r++)
		begin
			m_x[r]    = '0;
			m_y[r]    = '0;
			m_base[r] = '0;
			m_en[r]   = 1'b0;
			m_pal[r]  = '0;
		end
		build_table();
		for (r = 0; r < 4; r++)
			@(negedge CLK);
		RSTb = 1'b1;
		for (r = 0; r < N_ROWS; r++)
			apply_row(r);
		if (opaque_seen == 0)
			stop_run("No sprite pixel was displayed in any test");
		else
		begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* sources.f */
src/video_pkg.sv
src/sprite_pkg.sv
src/sprite_cand_if.sv
src/beam_counter.sv
src/memory_sprite.sv
src/sprite_bank.sv
src/pixel_fetch.sv
src/sprite_controller.sv
test/sprite_controller_chk.sv
test/tb_sprite_controller.sv

/* run.sh */
#!/bin/sh
# Builds the sprite engine testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_sprite_controller -f sources.f

status=0
out=$(./obj_dir/Vtb_sprite_controller 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
	exit 0
else
	echo "Simulation did not pass (exit status $status)"
	exit 1
fi
